// ==== source/cov_config.svh ====
`ifndef COV_CONFIG_SVH
`define COV_CONFIG_SVH

////////////////////////////////////////////////////////////
// datapath widths
////////////////////////////////////////////////////////////

// x, y and mean samples, signed
`define COV_DATA_W 16
// dx*y product, dx carries one extra bit
`define COV_PROD_W (2*`COV_DATA_W+1)
// accumulator and quotient
`define COV_ACC_W 48
// sample count field of the result
`define COV_CNT_W 16

////////////////////////////////////////////////////////////
// defaults
////////////////////////////////////////////////////////////

// samples per covariance
`define COV_NUM_SAMPLES_DEF 8

`endif

// ==== source/cov_pkg.sv ====
`include "cov_config.svh"

package cov_pkg;

    ////////////////////////////////////////////////////////////
    // command stream
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        OP_CLEAR  = 2'd0,   // drop partial set
        OP_MEAN   = 2'd1,   // load x mean from x field
        OP_SAMPLE = 2'd2,   // one x/y pair
        OP_RSVD   = 2'd3    // flagged, otherwise ignored
    } cov_op_e;

    typedef struct packed {
        cov_op_e                        op;
        logic signed [`COV_DATA_W-1:0] x;   // raw x, or mean for OP_MEAN
        logic signed [`COV_DATA_W-1:0] y;   // already centred
    } cov_cmd_t;

    // decode to execute
    typedef struct packed {
        logic signed [`COV_DATA_W:0]   dx;      // x minus mean, one bit growth
        logic signed [`COV_DATA_W-1:0] y;
        logic                          clear;   // restart accumulation
    } cov_operand_t;

    ////////////////////////////////////////////////////////////
    // divider and result
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        DIV_IDLE = 2'd0,    // waiting for a sum
        DIV_RUN  = 2'd1,    // one quotient bit per cycle
        DIV_HOLD = 2'd2     // result held until taken
    } cov_div_state_e;

    typedef struct packed {
        logic signed [`COV_ACC_W-1:0] cov;     // truncated toward zero
        logic [`COV_CNT_W-1:0]        count;   // samples in the sum
    } cov_result_t;

endpackage

// ==== source/cov_decode.sv ====
`timescale 1ns/100ps
`include "cov_config.svh"

module cov_decode
    import cov_pkg::*;
(
    input  logic         clk,
    input  logic         arst_n,
    input  cov_cmd_t     in_cmd,
    input  logic         in_valid,
    output logic         in_ready,
    input  logic         busy,        // result dividing or holding
    output logic         op_valid,
    output cov_operand_t op_data,
    output logic         bad_cmd
);

    localparam int DATA_W = `COV_DATA_W;

    logic                     accept;    // word taken this edge
    logic signed [DATA_W-1:0] mean_x;    // current x mean
    logic signed [DATA_W:0]   x_ext;     // sign extended x
    logic signed [DATA_W:0]   mean_ext;  // sign extended mean
    logic signed [DATA_W:0]   dx_next;   // centred x

    assign in_ready = ~busy;                  // stall while result pending
    assign accept   = in_valid & in_ready;

    assign x_ext    = {in_cmd.x[DATA_W-1], in_cmd.x};
    assign mean_ext = {mean_x[DATA_W-1], mean_x};
    assign dx_next  = x_ext - mean_ext;       // no overflow with the extra bit

    ////////////////////////////////////////////////////////////
    // opcode decode and mean register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mean_x   <= '0;
            op_valid <= 1'b0;
            bad_cmd  <= 1'b0;
        end else begin
            op_valid <= 1'b0;                 // single cycle pulses
            bad_cmd  <= 1'b0;
            if (accept) begin
                unique case (in_cmd.op)
                    OP_CLEAR:  op_valid <= 1'b1;        // travels down the pipe
                    OP_MEAN:   mean_x   <= in_cmd.x;    // no operand issued
                    OP_SAMPLE: op_valid <= 1'b1;
                    OP_RSVD:   bad_cmd  <= 1'b1;        // dropped
                    default:   bad_cmd  <= 1'b1;
                endcase
            end
        end
    end

    // operand payload, qualified by op_valid downstream
    always_ff @(posedge clk) begin
        if (accept) begin
            op_data.dx    <= dx_next;
            op_data.y     <= in_cmd.y;
            op_data.clear <= (in_cmd.op == OP_CLEAR);
        end
    end

endmodule

// ==== source/cov_execute.sv ====
`timescale 1ns/100ps
`include "cov_config.svh"

module cov_execute
    import cov_pkg::*;
#(
    parameter int NUM_SAMPLES = `COV_NUM_SAMPLES_DEF
) (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         op_valid,   // accepted every cycle
    input  cov_operand_t                 op_data,
    output logic                         sum_valid,
    output logic signed [`COV_ACC_W-1:0] sum,
    output logic [`COV_CNT_W-1:0]        count
);

    localparam int PROD_W = `COV_PROD_W;
    localparam int ACC_W  = `COV_ACC_W;
    localparam int CNT_W  = `COV_CNT_W;
    localparam logic [CNT_W-1:0] LAST = CNT_W'(NUM_SAMPLES - 1);   // index of final sample

    logic signed [PROD_W-1:0] prod;         // dx*y, stage 1
    logic                     prod_valid;
    logic                     prod_clear;   // clear rides along with stage 1
    logic signed [ACC_W-1:0]  acc;          // running sum, stage 2
    logic signed [ACC_W-1:0]  acc_next;
    logic [CNT_W-1:0]         cnt;          // samples already in acc
    logic                     last_add;     // closing sample of the set

    assign acc_next = acc + ACC_W'(prod);   // sign extended product
    assign last_add = prod_valid & ~prod_clear & (cnt == LAST);

    ////////////////////////////////////////////////////////////
    // stage 1, signed multiply
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prod_valid <= 1'b0;
        end else begin
            prod_valid <= op_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (op_valid) begin
            prod       <= $signed(op_data.dx) * $signed(op_data.y);   // 17x16 into 33
            prod_clear <= op_data.clear;
        end
    end

    ////////////////////////////////////////////////////////////
    // stage 2, accumulate and count
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            acc       <= '0;
            cnt       <= '0;
            sum_valid <= 1'b0;
        end else begin
            sum_valid <= last_add;             // pulse with the final add
            if (prod_valid) begin
                if (prod_clear || last_add) begin
                    acc <= '0;                 // next set starts fresh
                    cnt <= '0;
                end else begin
                    acc <= acc_next;
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

    // finished sum, read by result on sum_valid
    always_ff @(posedge clk) begin
        if (last_add) begin
            sum   <= acc_next;
            count <= cnt + 1'b1;               // equals NUM_SAMPLES
        end
    end

endmodule

// ==== source/cov_result.sv ====
`timescale 1ns/100ps
`include "cov_config.svh"

module cov_result
    import cov_pkg::*;
#(
    parameter int NUM_SAMPLES = `COV_NUM_SAMPLES_DEF
) (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         sum_valid,
    input  logic signed [`COV_ACC_W-1:0] sum,
    input  logic [`COV_CNT_W-1:0]        count,
    output logic                         busy,
    output cov_result_t                  out_res,
    output logic                         out_valid,
    input  logic                         out_ready
);

    localparam int ACC_W  = `COV_ACC_W;
    localparam int STEP_W = $clog2(ACC_W + 1);
    localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(ACC_W);        // sign fix cycle
    localparam logic [ACC_W-1:0]  DIVISOR   = ACC_W'(NUM_SAMPLES - 1);

    cov_div_state_e    state;
    logic [STEP_W-1:0] step;       // quotient bits done
    logic [ACC_W-1:0]  quo;        // dividend shifts out, quotient shifts in
    logic [ACC_W-1:0]  rem;        // partial remainder
    logic [ACC_W:0]    rem_sh;     // remainder with next dividend bit
    logic [ACC_W:0]    rem_diff;   // trial subtraction
    logic              neg;        // sign of the sum

    // rises with sum_valid so decode stalls at once
    assign busy     = sum_valid | (state != DIV_IDLE);
    assign rem_sh   = {rem, quo[ACC_W-1]};
    assign rem_diff = rem_sh - {1'b0, DIVISOR};   // msb set means borrow

    ////////////////////////////////////////////////////////////
    // divider FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= DIV_IDLE;
            step      <= '0;
            out_valid <= 1'b0;
        end else begin
            unique case (state)
                DIV_IDLE: begin
                    if (sum_valid) begin
                        state <= DIV_RUN;
                        step  <= '0;
                    end
                end
                DIV_RUN: begin
                    if (step == LAST_STEP) begin
                        state     <= DIV_HOLD;   // ACC_W+2 cycles after sum_valid
                        out_valid <= 1'b1;
                    end else begin
                        step <= step + 1'b1;
                    end
                end
                DIV_HOLD: begin
                    if (out_ready) begin
                        state     <= DIV_IDLE;   // consumer took it
                        out_valid <= 1'b0;
                    end
                end
                default: state <= DIV_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // restoring division on the magnitude
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (state == DIV_IDLE && sum_valid) begin
            quo           <= sum[ACC_W-1] ? $unsigned(-sum) : $unsigned(sum);
            rem           <= '0;
            neg           <= sum[ACC_W-1];
            out_res.count <= count;              // output idle here, safe to load
        end else if (state == DIV_RUN) begin
            if (step == LAST_STEP) begin
                // sign restored, truncates toward zero
                out_res.cov <= neg ? -$signed(quo) : $signed(quo);
            end else if (!rem_diff[ACC_W]) begin
                rem <= rem_diff[ACC_W-1:0];      // subtract fits
                quo <= {quo[ACC_W-2:0], 1'b1};
            end else begin
                rem <= rem_sh[ACC_W-1:0];        // restore
                quo <= {quo[ACC_W-2:0], 1'b0};
            end
        end
    end

endmodule

// ==== source/cov_top.sv ====
`timescale 1ns/100ps
`include "cov_config.svh"

module cov_top
    import cov_pkg::*;
#(
    parameter int NUM_SAMPLES = `COV_NUM_SAMPLES_DEF
) (
    input  logic        clk,
    input  logic        arst_n,
    input  cov_cmd_t    in_cmd,
    input  logic        in_valid,
    output logic        in_ready,
    output cov_result_t out_res,
    output logic        out_valid,
    input  logic        out_ready,
    output logic        bad_cmd     // reserved opcode seen
);

    logic                         op_valid;    // decode to execute
    cov_operand_t                 op_data;
    logic                         sum_valid;   // execute to result
    logic signed [`COV_ACC_W-1:0] sum;
    logic [`COV_CNT_W-1:0]        count;
    logic                         busy;        // result back to decode

    ////////////////////////////////////////////////////////////
    // decode, execute, result
    ////////////////////////////////////////////////////////////

    cov_decode i_decode (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_cmd   (in_cmd),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .busy     (busy),
        .op_valid (op_valid),
        .op_data  (op_data),
        .bad_cmd  (bad_cmd)
    );

    cov_execute #(.NUM_SAMPLES(NUM_SAMPLES)) i_execute (
        .clk       (clk),
        .arst_n    (arst_n),
        .op_valid  (op_valid),
        .op_data   (op_data),
        .sum_valid (sum_valid),
        .sum       (sum),
        .count     (count)
    );

    cov_result #(.NUM_SAMPLES(NUM_SAMPLES)) i_result (
        .clk       (clk),
        .arst_n    (arst_n),
        .sum_valid (sum_valid),
        .sum       (sum),
        .count     (count),
        .busy      (busy),
        .out_res   (out_res),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

endmodule

// ==== tests/cov_checker.sv ====
`timescale 1ns/100ps
`include "cov_config.svh"

module cov_checker
    import cov_pkg::*;
#(
    parameter int NUM_SAMPLES = `COV_NUM_SAMPLES_DEF,
    parameter int NAME_W      = 96
) (
    input  logic                         clk,
    input  logic                         arst_n,
    input  cov_result_t                  out_res,
    input  logic                         out_valid,
    input  logic                         out_ready,
    input  logic                         bad_cmd,
    input  logic                         exp_valid,     // queue one expected result
    input  logic signed [`COV_ACC_W-1:0] exp_cov,
    input  logic [NAME_W-1:0]            exp_name,
    input  logic                         final_check,   // end of run checks
    input  int                           exp_bad,
    output int                           checked,
    output int                           errors
);

    localparam int CNT_W = `COV_CNT_W;

    logic signed [`COV_ACC_W-1:0] cov_q [$];    // expected, in order
    logic [NAME_W-1:0]            name_q [$];
    logic signed [`COV_ACC_W-1:0] want;
    logic [NAME_W-1:0]            want_name;
    int                           bad_seen;

    always @(posedge clk) begin
        if (!arst_n) begin
            checked  = 0;
            errors   = 0;
            bad_seen = 0;
            cov_q.delete();
            name_q.delete();
        end else begin
            if (exp_valid) begin
                cov_q.push_back(exp_cov);
                name_q.push_back(exp_name);
            end
            if (bad_cmd) bad_seen++;
            if (out_valid && out_ready) begin              // output handshake
                if (cov_q.size() == 0) begin
                    $display("Unexpected output %0d with no test waiting", out_res.cov);
                    errors++;
                end else begin
                    want      = cov_q.pop_front();
                    want_name = name_q.pop_front();
                    checked++;
                    if (out_res.cov !== want) begin
                        $display("Error: %s expected %0d actual %0d",
                                 want_name, want, out_res.cov);
                        errors++;
                    end else if (out_res.count !== CNT_W'(NUM_SAMPLES)) begin
                        $display("Error: %s count expected %0d actual %0d",
                                 want_name, NUM_SAMPLES, out_res.count);
                        errors++;
                    end else begin
                        $display("Pass: %s cov %0d count %0d",
                                 want_name, out_res.cov, out_res.count);
                    end
                end
            end
            if (final_check) begin
                if (bad_seen != exp_bad) begin
                    $display("Error: bad_cmd_count expected %0d actual %0d", exp_bad, bad_seen);
                    errors++;
                end
                if (cov_q.size() != 0) begin
                    $display("%0d expected results never arrived", cov_q.size());
                    errors++;
                end
            end
        end
    end

endmodule

// ==== tests/cov_assert.sv ====
`timescale 1ns/100ps

module cov_assert
    import cov_pkg::*;
(
    input logic        clk,
    input logic        arst_n,
    input logic        in_ready,
    input logic        out_valid,
    input logic        out_ready,
    input cov_result_t out_res
);

    // held word must not move while the consumer stalls
    property p_stable_stall;
        @(posedge clk) disable iff (!arst_n)
            (out_valid && !out_ready) |=> (out_valid && $stable(out_res));
    endproperty

    property p_input_stalled;
        @(posedge clk) disable iff (!arst_n) out_valid |-> !in_ready;
    endproperty

    property p_reset_state;
        @(posedge clk) !arst_n |-> (!out_valid && in_ready);
    endproperty

    a_stable_stall: assert property (p_stable_stall)
        else $error("out_res changed or dropped while stalled");
    a_input_stalled: assert property (p_input_stalled)
        else $error("in_ready high with a result pending");
    a_reset_state: assert property (p_reset_state)
        else $error("out_valid or in_ready wrong in reset");

endmodule

bind cov_top cov_assert i_assert (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_res   (out_res)
);

// ==== tests/cov_tb.sv ====
`timescale 1ns/100ps
`include "cov_config.svh"

module cov_tb
    import cov_pkg::*;
();

    localparam int NS       = `COV_NUM_SAMPLES_DEF;
    localparam int DATA_W   = `COV_DATA_W;
    localparam int ACC_W    = `COV_ACC_W;
    localparam int NAME_W   = 96;     // twelve characters
    localparam int N_TESTS  = 10;
    localparam int WAIT_MAX = 400;    // cycles before a wait gives up

    typedef struct packed {
        logic [NAME_W-1:0]         name;
        logic [DATA_W-1:0]         mean;
        logic [NS-1:0][DATA_W-1:0] x;
        logic [NS-1:0][DATA_W-1:0] y;
        logic signed [ACC_W-1:0]   cov;         // expected covariance
        logic                      clear_mid;   // partial set then OP_CLEAR
        logic                      rsvd;        // OP_RSVD word first
        logic                      stall;       // random gaps and out_ready low
    } test_t;

    test_t                    tests [N_TESTS];
    logic                     clk;
    logic                     arst_n;
    cov_cmd_t                 in_cmd;
    logic                     in_valid;
    logic                     in_ready;
    cov_result_t              out_res;
    logic                     out_valid;
    logic                     out_ready;
    logic                     bad_cmd;
    logic                     exp_valid;     // to checker
    logic signed [ACC_W-1:0]  exp_cov;
    logic [NAME_W-1:0]        exp_name;
    logic                     final_check;
    int                       exp_bad;       // OP_RSVD words sent
    int                       checked;       // from checker
    int                       errors;
    logic                     stall_mode;
    logic                     timed_out;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;              // 40 ns period
    end

    // consumer, stalls at random in stall tests
    initial begin
        out_ready = 1'b1;
        forever begin
            @(negedge clk);
            out_ready = stall_mode ? ($urandom_range(2, 0) == 0) : 1'b1;
        end
    end

    cov_top #(.NUM_SAMPLES(NS)) i_dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_cmd    (in_cmd),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_res   (out_res),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .bad_cmd   (bad_cmd)
    );

    cov_checker #(.NUM_SAMPLES(NS), .NAME_W(NAME_W)) i_checker (.*);

    ////////////////////////////////////////////////////////////
    // stimulus table
    ////////////////////////////////////////////////////////////

    function automatic test_t make_test(input logic [NAME_W-1:0] name, input int mean,
                                        input int x0, input int x_step, input int y0,
                                        input int y_step, input logic [2:0] flags);
        test_t t;
        t.name = name;
        t.mean = DATA_W'(mean);
        for (int i = 0; i < NS; i++) begin
            t.x[i] = DATA_W'(x0 + i * x_step);   // linear ramps
            t.y[i] = DATA_W'(y0 + i * y_step);
        end
        t.cov = '0;
        {t.clear_mid, t.rsvd, t.stall} = flags;
        return t;
    endfunction

    // sum of (x - mean) * y over n - 1, wide signed math
    function automatic logic signed [ACC_W-1:0] expected_cov(input test_t t);
        longint sum;
        sum = 0;
        for (int i = 0; i < NS; i++) begin
            sum += (longint'($signed(t.x[i])) - longint'($signed(t.mean)))
                   * longint'($signed(t.y[i]));
        end
        return ACC_W'(sum / longint'(NS - 1));  // integer divide truncates toward zero
    endfunction

    task automatic fill_table();
        tests[0] = make_test("pos_basic", 0, 1, 1, 2, 3, 3'b000);
        tests[1] = make_test("neg_trunc", 3, 0, 1, 5, -2, 3'b000);     // -92/7
        tests[2] = make_test("zero_sum", 0, 5, 0, -7, 2, 3'b000);
        tests[3] = make_test("mean_load", 100, 90, 5, 4, -1, 3'b000);
        tests[4] = make_test("clear_mid", -50, -60, 3, 1, 2, 3'b100);
        tests[5] = make_test("rsvd_op", 7, 10, -4, -3, 1, 3'b010);
        tests[6] = make_test("ext_pos", 32767, -32768, 0, -32768, 0, 3'b000);
        tests[7] = make_test("ext_neg", -32768, 32767, 0, -32768, 0, 3'b000);
        tests[8] = make_test("stall_rand_a", 0, 0, 0, 0, 0, 3'b001);
        tests[9] = make_test("stall_rand_b", 0, 0, 0, 0, 0, 3'b101);
        for (int k = 8; k < N_TESTS; k++) begin
            tests[k].mean = DATA_W'($urandom());
            for (int i = 0; i < NS; i++) begin
                tests[k].x[i] = DATA_W'($urandom());
                tests[k].y[i] = DATA_W'($urandom());
            end
        end
        for (int k = 0; k < N_TESTS; k++) begin
            tests[k].cov = expected_cov(tests[k]);   // expected column of the table
        end
    endtask

    ////////////////////////////////////////////////////////////
    // drivers, called on a falling edge
    ////////////////////////////////////////////////////////////

    task automatic send_word(input cov_op_e op, input logic [DATA_W-1:0] x,
                             input logic [DATA_W-1:0] y);
        int waited;
        waited = 0;
        if (timed_out) return;
        if (stall_mode) repeat ($urandom_range(3, 0)) @(negedge clk);   // input gap
        in_cmd.op = op;
        in_cmd.x  = x;
        in_cmd.y  = y;
        in_valid  = 1'b1;
        while (!in_ready && !timed_out) begin      // in_ready settled since posedge
            @(negedge clk);
            waited++;
            if (waited > WAIT_MAX) begin
                $display("Timeout: in_ready stayed low for %0d cycles", WAIT_MAX);
                timed_out = 1'b1;
            end
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic run_test(input int idx);
        test_t t;
        int    waited;
        t          = tests[idx];
        waited     = 0;
        stall_mode = t.stall;
        if (t.rsvd) begin
            send_word(OP_RSVD, t.x[0], t.y[0]);
            exp_bad++;
        end
        send_word(OP_MEAN, t.mean, '0);
        if (t.clear_mid) begin
            repeat (3) send_word(OP_SAMPLE, DATA_W'($urandom()), DATA_W'($urandom()));
            send_word(OP_CLEAR, '0, '0);             // partial set dropped
        end
        exp_cov   = t.cov;
        exp_name  = t.name;
        exp_valid = 1'b1;
        @(negedge clk);
        exp_valid = 1'b0;
        for (int i = 0; i < NS; i++) send_word(OP_SAMPLE, t.x[i], t.y[i]);
        while (checked <= idx && !timed_out) begin   // result of this set
            @(negedge clk);
            waited++;
            if (waited > WAIT_MAX) begin
                $display("Timeout: no result for test %s", t.name);
                timed_out = 1'b1;
            end
        end
    endtask

    initial begin
        void'($urandom(31838));                      // single seed for the run
        arst_n      = 1'b0;
        in_cmd      = '0;
        in_valid    = 1'b0;
        exp_valid   = 1'b0;
        exp_cov     = '0;
        exp_name    = '0;
        final_check = 1'b0;
        exp_bad     = 0;
        stall_mode  = 1'b0;
        timed_out   = 1'b0;
        fill_table();
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        for (int i = 0; i < N_TESTS; i++) begin
            if (!timed_out) run_test(i);
        end
        final_check = 1'b1;                          // lost results, bad_cmd count
        @(negedge clk);
        final_check = 1'b0;
        $display("Tests %0d, results checked %0d, errors %0d", N_TESTS, checked, errors);
        if (errors == 0 && !timed_out) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+source
source/cov_pkg.sv
source/cov_decode.sv
source/cov_execute.sv
source/cov_result.sv
source/cov_top.sv
tests/cov_checker.sv
tests/cov_assert.sv
tests/cov_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Verilator build and run of the covariance testbench
set -u
cd "$(dirname "$0")" || exit 1

top=cov_tb
log=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module "$top" -f tb.f -o "$top" > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "BUILD FAILED"
    exit 1
fi

./obj_dir/"$top" > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
fi

if grep -qx "No errors" "$log"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1
